// ==== compile.f ====
+incdir+include
src/txt_video_pkg.sv
src/txt_bus_pkg.sv
src/txt_video_timing.sv
src/txt_cpu_port.sv
src/txt_tile_store.sv
src/txt_char_rom.sv
src/txt_pixel_shifter.sv
src/txt_layer_top.sv
testbench/txt_layer_tb.sv

// ==== src/txt_bus_pkg.sv ====
// ****************************************
// Text layer CPU bus package
// Write request, regions and address unscramble
// ****************************************
`default_nettype none

package txt_bus_pkg;

    typedef logic [11:0] cpu_addr_t;        // Region in 11:10, tile index below
    typedef logic [7:0]  cpu_data_t;
    typedef logic [1:0]  region_t;

    // Address bits 11:10
    localparam region_t REGION_TILE   = 2'd0;
    localparam region_t REGION_COLOUR = 2'd1;
    // Regions 2 and 3 are accepted and dropped

    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t data;
    } cpu_wr_t;

    // Board wiring reverses the low ten address lines
    function automatic cpu_addr_t unscramble_addr(input cpu_addr_t addr);
        cpu_addr_t plain;
        plain[11:10] = addr[11:10];         // Region bits come through straight
        for (int i = 0; i < 10; i++) begin
            plain[i] = addr[9 - i];
        end
        return plain;
    endfunction

endpackage

`default_nettype wire

// ==== src/txt_char_rom.sv ====
// ****************************************
// Text layer character ROM
// 2 KB of tile rows, loaded before the game runs
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module txt_char_rom import txt_video_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire rom_addr_t rd_addr,         // Tile code then v[2:0]
    output rom_row_t       row,
    input  wire rom_addr_t prog_addr,
    input  wire rom_row_t  prog_data,
    input  wire logic      prog_we
);

    rom_row_t rom [ROM_DEPTH];

    // Load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            rom[prog_addr] <= prog_data;
        end
    end

    // Read every clk, the address holds for a whole tile
    always_ff @(posedge clk) begin
        row <= rom[rd_addr];
    end

    // Loading is a reset-time job only
    a_load_in_reset: assert property (
        @(posedge clk) disable iff (reset) !prog_we
    ) else $error("ROM write while the scan is running");

endmodule

`default_nettype wire

// ==== src/txt_cpu_port.sv ====
// ****************************************
// Text layer CPU write port
// Credit flow write queue with address unscramble
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module txt_cpu_port import txt_bus_pkg::*; #(
    parameter int WQ_DEPTH = 4              // Also the host's starting credits
) (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire cpu_wr_t cpu_req,           // Address still scrambled
    input  wire logic    cpu_valid,
    output logic         credit_return,     // One clk per write leaving the queue
    output logic         wr_pending,
    output cpu_wr_t      wr_req,            // Head entry, plain address
    input  wire logic    wr_taken
);

    localparam int PTR_W = (WQ_DEPTH > 1) ? $clog2(WQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(WQ_DEPTH + 1);

    typedef logic [PTR_W-1:0] wq_ptr_t;
    typedef logic [CNT_W-1:0] wq_cnt_t;

    cpu_wr_t queue [WQ_DEPTH];
    wq_ptr_t wr_ptr;
    wq_ptr_t rd_ptr;
    wq_cnt_t count;                         // Entries held
    logic    full;
    logic    push;
    logic    pop;

    // Depth need not be a power of two
    function automatic wq_ptr_t ptr_next(input wq_ptr_t ptr);
        if (ptr == wq_ptr_t'(WQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == wq_cnt_t'(WQ_DEPTH));
    assign push = cpu_valid && !full;       // Overflow is a host bug, never stored
    assign pop  = wr_taken && wr_pending;

    // Address is unscrambled on the way in
    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr].addr <= unscramble_addr(cpu_req.addr);
            queue[wr_ptr].data <= cpu_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;           // Written or dropped, credit comes back
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // Head of queue, region bits still select the RAM downstream
    assign wr_pending = (count != '0);
    assign wr_req     = queue[rd_ptr];

    // Host sends only while it holds a credit
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) cpu_valid |-> !full
    ) else $error("write queue overflow, host ran out of credits");

    // Store only takes what is offered
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset) wr_taken |-> wr_pending
    ) else $error("write taken from an empty queue");

endmodule

`default_nettype wire

// ==== src/txt_layer_top.sv ====
// ****************************************
// Text layer top
// CPU port, timing, tile store, ROM and shifter
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module txt_layer_top import txt_video_pkg::*, txt_bus_pkg::*; #(
    parameter int WQ_DEPTH = 4
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire cpu_wr_t   cpu_req,
    input  wire logic      cpu_valid,
    output logic           credit_return,
    input  wire rom_addr_t prog_addr,       // ROM load, during reset
    input  wire rom_row_t  prog_data,
    input  wire logic      prog_we,
    input  wire logic      flip,
    output txt_pixel_t     pixel
);

    logic         pxl_cen;
    scan_pos_t    scan_pos;
    logic         wr_pending;
    cpu_wr_t      wr_req;                   // Unscrambled head of queue
    logic         wr_taken;
    tile_code_t   code;
    tile_colour_t colour;
    rom_row_t     row;

    txt_cpu_port #(
        .WQ_DEPTH      (WQ_DEPTH)
    ) u_cpu_port (
        .clk           (clk),
        .reset         (reset),
        .cpu_req       (cpu_req),
        .cpu_valid     (cpu_valid),
        .credit_return (credit_return),
        .wr_pending    (wr_pending),
        .wr_req        (wr_req),
        .wr_taken      (wr_taken)
    );

    txt_video_timing u_timing (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .scan_pos (scan_pos)
    );

    txt_tile_store u_store (
        .clk        (clk),
        .reset      (reset),
        .pxl_cen    (pxl_cen),
        .scan_pos   (scan_pos),
        .wr_pending (wr_pending),
        .wr_req     (wr_req),
        .wr_taken   (wr_taken),
        .code       (code),
        .colour     (colour)
    );

    // Row within the tile comes straight from the scan
    txt_char_rom u_rom (
        .clk       (clk),
        .reset     (reset),
        .rd_addr   ({code, scan_pos.v[2:0]}),
        .row       (row),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we)
    );

    txt_pixel_shifter u_shifter (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .scan_pos (scan_pos),
        .flip     (flip),
        .row      (row),
        .colour   (colour),
        .pixel    (pixel)
    );

endmodule

`default_nettype wire

// ==== src/txt_pixel_shifter.sv ====
// ****************************************
// Text layer pixel shifter
// Row latch, flip-aware shift and pixel output
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module txt_pixel_shifter import txt_video_pkg::*; (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         pxl_cen,
    input  wire scan_pos_t    scan_pos,
    input  wire logic         flip,         // Mirror each tile row
    input  wire rom_row_t     row,
    input  wire tile_colour_t colour,
    output txt_pixel_t        pixel
);

    // Row for a tile is latched as the scan leaves it
    localparam int PIPE_LEN = 8;

    rom_row_t     shift_row;
    tile_colour_t tile_colour;
    scan_pos_t    pos_dly [PIPE_LEN];       // Scan position, oldest at the end
    logic         load;
    logic         out_bit;

    assign load    = (scan_pos.h[2:0] == 3'd7);
    assign out_bit = flip ? shift_row[7] : shift_row[0];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (load) begin
                shift_row   <= row;         // Old row's last bit goes out this cycle
                tile_colour <= colour;
            end else if (flip) begin
                shift_row <= {shift_row[6:0], 1'b0};
            end else begin
                shift_row <= {1'b0, shift_row[7:1]};
            end
        end
    end

    // Coordinates ride along with the data
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PIPE_LEN; i++) begin
                pos_dly[i] <= '0;
            end
        end else if (pxl_cen) begin
            pos_dly[0] <= scan_pos;
            for (int i = 1; i < PIPE_LEN; i++) begin
                pos_dly[i] <= pos_dly[i-1];
            end
        end
    end

    // Valid strobes once per pixel, blanking stays low
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel <= '0;
        end else begin
            pixel.valid <= pxl_cen && pos_dly[PIPE_LEN-1].visible;
            if (pxl_cen) begin
                pixel.h      <= pos_dly[PIPE_LEN-1].h;
                pixel.v      <= pos_dly[PIPE_LEN-1].v;
                pixel.colour <= tile_colour;
                pixel.opaque <= out_bit;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/txt_tile_store.sv ====
// ****************************************
// Text layer tile store
// Code and colour RAMs, scan reads between CPU writes
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module txt_tile_store import txt_video_pkg::*, txt_bus_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      pxl_cen,
    input  wire scan_pos_t scan_pos,
    input  wire logic      wr_pending,
    input  wire cpu_wr_t   wr_req,
    output logic           wr_taken,
    output tile_code_t     code,            // Valid one clk after the read
    output tile_colour_t   colour
);

    tile_code_t   code_ram   [TILE_COUNT];
    tile_colour_t colour_ram [TILE_COUNT];  // Same colour for all 8x8 pixels
    tile_idx_t    rd_idx;
    tile_idx_t    wr_idx;
    region_t      wr_region;
    logic         scan_rd;

    // 32x32 tiles, row from v[7:3], column from h[7:3]
    assign rd_idx  = {scan_pos.v[7:3], scan_pos.h[7:3]};
    assign scan_rd = pxl_cen && (scan_pos.h[2:0] == 3'd0);   // First pixel of a tile

    assign wr_idx    = wr_req.addr[9:0];
    assign wr_region = wr_req.addr[11:10];
    assign wr_taken  = wr_pending && !pxl_cen;   // Scan owns the cen cycles

    // Scan read
    always_ff @(posedge clk) begin
        if (scan_rd) begin
            code   <= code_ram[rd_idx];
            colour <= colour_ram[rd_idx];
        end
    end

    // CPU writes, regions 2 and 3 fall through untouched
    always_ff @(posedge clk) begin
        if (wr_taken && (wr_region == REGION_TILE)) begin
            code_ram[wr_idx] <= wr_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_taken && (wr_region == REGION_COLOUR)) begin
            colour_ram[wr_idx] <= wr_req.data[3:0];   // Upper nibble unused
        end
    end

    // Every pixel slot leaves a free write slot behind it, so the queue drains
    a_write_slot: assert property (
        @(posedge clk) disable iff (reset) pxl_cen |=> !pxl_cen
    ) else $error("two pixel enables in a row, no write slot");

endmodule

`default_nettype wire

// ==== src/txt_video_pkg.sv ====
// ****************************************
// Text layer video package
// Screen geometry, scan position and pixel types
// ****************************************
`default_nettype none

package txt_video_pkg;

    // Geometry is fixed by the board
    localparam int H_TOTAL    = 320;        // Pixel enables per line
    localparam int V_TOTAL    = 264;        // Lines per frame
    localparam int H_VISIBLE  = 256;
    localparam int V_VISIBLE  = 256;
    localparam int TILE_COLS  = 32;         // 8 pixel wide tiles
    localparam int TILE_ROWS  = 32;         // 8 line high tiles
    localparam int TILE_COUNT = TILE_COLS * TILE_ROWS;
    localparam int ROM_DEPTH  = 2048;       // 256 codes x 8 rows

    typedef logic [7:0]  coord_t;           // Visible x or y
    typedef logic [8:0]  scan_cnt_t;        // Raw counter, blanking included
    typedef logic [7:0]  tile_code_t;
    typedef logic [3:0]  tile_colour_t;
    typedef logic [9:0]  tile_idx_t;        // Tile row then column
    typedef logic [10:0] rom_addr_t;        // Code then pixel row
    typedef logic [7:0]  rom_row_t;         // One 8 pixel row, bit per pixel

    // Where the scan is right now
    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   visible;                    // Inside 256x256
    } scan_pos_t;

    // One output pixel, tagged with its own position
    typedef struct packed {
        logic         valid;
        coord_t       h;
        coord_t       v;
        tile_colour_t colour;
        logic         opaque;               // Set where the ROM bit is 1
    } txt_pixel_t;

endpackage

`default_nettype wire

// ==== src/txt_video_timing.sv ====
// ****************************************
// Text layer video timing
// Pixel enable, h/v counters and blanking
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module txt_video_timing import txt_video_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    output logic      pxl_cen,              // High on every second clk
    output scan_pos_t scan_pos
);

    scan_cnt_t h_cnt;                       // 0..319, one step per pixel
    scan_cnt_t v_cnt;                       // 0..263

    // Divide by two
    always_ff @(posedge clk) begin
        if (reset) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pxl_cen) begin
            if (h_cnt == scan_cnt_t'(H_TOTAL - 1)) begin
                h_cnt <= '0;                // End of line
                if (v_cnt == scan_cnt_t'(V_TOTAL - 1)) begin
                    v_cnt <= '0;            // End of frame
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // Low bits only, blanking is flagged by visible
    assign scan_pos.h       = h_cnt[7:0];
    assign scan_pos.v       = v_cnt[7:0];
    assign scan_pos.visible = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);

    // Wrap must be hit exactly, the scan reads rely on h[2:0] cycling
    a_h_in_range: assert property (
        @(posedge clk) disable iff (reset) h_cnt < scan_cnt_t'(H_TOTAL)
    ) else $error("h counter ran past the line length");

endmodule

`default_nettype wire

// ==== include/txt_tb_model.svh ====
// ****************************************
// Text layer reference model
// RAM and ROM images and pixel prediction
// ****************************************
`ifndef TXT_TB_MODEL_SVH
`define TXT_TB_MODEL_SVH

logic [7:0] rom_img    [2048];              // Code then row, one bit per pixel
logic [7:0] code_img   [1024];              // Index is tile row then column
logic [3:0] colour_img [1024];

// Board mirrors the low ten address lines, same swap both ways
function automatic logic [9:0] mirror_low10(input logic [11:0] addr);
    logic [9:0] idx;
    for (int i = 0; i < 10; i++) begin
        idx[9 - i] = addr[i];
    end
    return idx;
endfunction

// Region in bits 11:10 picks the image
function automatic void apply_write(input logic [11:0] addr, input logic [7:0] data);
    case (addr[11:10])
        2'd0:    code_img[mirror_low10(addr)] = data;
        2'd1:    colour_img[mirror_low10(addr)] = data[3:0];   // Low nibble only
        default: ;                          // Regions 2 and 3 hold nothing
    endcase
endfunction

// One colour per 8x8 tile
function automatic logic [3:0] expect_colour(input logic [7:0] h, input logic [7:0] v);
    return colour_img[{v[7:3], h[7:3]}];
endfunction

function automatic logic expect_opaque(input logic [7:0] h, input logic [7:0] v,
                                       input logic flipped);
    logic [7:0] code;
    logic [7:0] bits;
    code = code_img[{v[7:3], h[7:3]}];
    bits = rom_img[{code, v[2:0]}];        // Row of the tile at this line
    if (flipped) begin
        return bits[3'd7 - h[2:0]];         // Mirrored, bit 7 leftmost
    end
    return bits[h[2:0]];
endfunction

`endif

// ==== testbench/txt_layer_tb.sv ====
// ****************************************
// Text layer testbench
// Random ROM and tile writes, frames checked against a model
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module txt_layer_tb import txt_video_pkg::*, txt_bus_pkg::*; ();

    localparam int          WQ_DEPTH    = 4;
    localparam logic [31:0] SEED        = 32'hc5d03197;
    localparam int          MODE_CLEAR  = 0;        // Zero every code and colour
    localparam int          MODE_RANDOM = 1;
    localparam int          MODE_DROP   = 2;        // Regions 2 and 3 only
    localparam int          DRAIN_LIMIT = 1000;     // Clks to wait for the last credits
    localparam longint      FRAME_CLKS  = H_TOTAL * V_TOTAL * 2;
    localparam longint      WRITE_CLKS  = (2 * TILE_COUNT + 2048 + 256) * 4;
    // Up to two frames per frame check, four checks, plus writes and ROM load
    localparam longint      RUN_CLKS    = 8 * FRAME_CLKS + WRITE_CLKS + ROM_DEPTH + 100;
    localparam longint      WATCHDOG_NS = RUN_CLKS * 100 * 5 / 4;

    logic        clk;
    logic        reset;
    cpu_wr_t     cpu_req;
    logic        cpu_valid;
    logic        credit_return;
    rom_addr_t   prog_addr;
    rom_row_t    prog_data;
    logic        prog_we;
    logic        flip;
    txt_pixel_t  pixel;

    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          passed;
    bit          seen [H_VISIBLE * V_VISIBLE];  // Positions hit in this frame

    `include "txt_tb_model.svh"

    txt_layer_top #(
        .WQ_DEPTH      (WQ_DEPTH)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .cpu_req       (cpu_req),
        .cpu_valid     (cpu_valid),
        .credit_return (credit_return),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .prog_we       (prog_we),
        .flip          (flip),
        .pixel         (pixel)
    );

    always #50 clk = ~clk;                          // 100 ns period

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input int num, input string name, input int mark);
        if (errors == mark) begin
            passed++;
        end
        $display("test %0d %s: %s", num, name, (errors == mark) ? "pass" : "fail");
    endtask

    // One byte per clk through the programming port
    task automatic load_rom();
        for (int a = 0; a < ROM_DEPTH; a++) begin
            @(posedge clk);
            prog_addr <= rom_addr_t'(a);
            prog_data <= rom_img[a];
            prog_we   <= 1'b1;
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // Host only sends while it holds a credit
    task automatic stream_writes(input int total, input int mode);
        int          credits;
        int          sent;
        int          returned;
        int          waited;
        logic [31:0] r;
        cpu_wr_t     req;
        credits  = WQ_DEPTH;
        sent     = 0;
        returned = 0;
        waited   = 0;
        while ((sent < total || credits < WQ_DEPTH) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            if (credit_return) begin
                credits++;
                returned++;
            end
            if (sent < total && credits > 0) begin
                r = next_random();
                case (mode)
                    MODE_CLEAR: req.addr = {1'b0, sent[10], mirror_low10(12'(sent))};
                    MODE_DROP:  req.addr = {1'b1, r[10:0]};
                    default:    req.addr = r[11:0];
                endcase
                req.data = (mode == MODE_CLEAR) ? 8'h00 : r[19:12];
                apply_write(req.addr, req.data);
                cpu_req   <= req;
                cpu_valid <= 1'b1;
                credits--;
                sent++;
            end else begin
                cpu_valid <= 1'b0;
                waited    += (sent == total) ? 1 : 0;
            end
            compare(credits >= 0 && credits <= WQ_DEPTH, 1'b1, "host credit count in range");
        end
        compare(credits, WQ_DEPTH, "credits back after the writes");
        compare(returned, total, "credits returned");
    endtask

    // One frame from the pixel at (0, 0) to the next one
    task automatic check_frame(input logic flipped);
        int          count;
        longint      cycles;
        logic        started;
        logic        done;
        logic [15:0] pos;
        string       where;
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        count   = 0;
        cycles  = 0;
        started = 1'b0;
        while (!started && cycles < 2 * FRAME_CLKS) begin
            @(posedge clk);
            cycles++;
            started = pixel.valid && pixel.h == 8'd0 && pixel.v == 8'd0;
        end
        if (!started) begin
            errors++;
            $display("no pixel at the top left corner within two frames");
        end
        done = !started;
        while (!done && cycles < 4 * FRAME_CLKS) begin
            if (pixel.valid) begin
                pos   = {pixel.v, pixel.h};
                where = $sformatf("pixel (%0d, %0d)", pixel.h, pixel.v);
                compare(seen[pos], 1'b0, {where, " emitted once"});
                seen[pos] = 1'b1;
                count++;
                compare(pixel.colour, expect_colour(pixel.h, pixel.v), {where, " colour"});
                compare(pixel.opaque, expect_opaque(pixel.h, pixel.v, flipped),
                        {where, " opaque"});
            end
            @(posedge clk);
            cycles++;
            done = pixel.valid && pixel.h == 8'd0 && pixel.v == 8'd0;
        end
        compare(count, H_VISIBLE * V_VISIBLE, "valid pixels in one frame");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int          mark;
        logic [31:0] r;
        clk        = 1'b0;
        reset      = 1'b1;
        cpu_req    = '0;
        cpu_valid  = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        prog_we    = 1'b0;
        flip       = 1'b0;
        errors     = 0;
        checks     = 0;
        passed     = 0;
        rand_state = SEED;
        for (int a = 0; a < ROM_DEPTH; a++) begin
            r          = next_random();
            rom_img[a] = r[23:16];
        end
        repeat (8) @(posedge clk);
        load_rom();                                 // Layer stays in reset while loading
        @(posedge clk);
        reset <= 1'b0;

        mark = errors;
        stream_writes(2 * TILE_COUNT, MODE_CLEAR); // All codes and colours to 0
        check_frame(1'b0);
        finish_test(1, "ROM load", mark);

        mark = errors;
        stream_writes(2048, MODE_RANDOM);
        finish_test(2, "credited writes", mark);

        mark = errors;
        check_frame(1'b0);
        finish_test(3, "tile and colour lookup", mark);

        mark = errors;
        @(posedge clk);
        flip <= 1'b1;
        check_frame(1'b1);
        finish_test(4, "flip", mark);

        mark = errors;
        @(posedge clk);
        flip <= 1'b0;
        stream_writes(256, MODE_DROP);              // Model images stay as they are
        check_frame(1'b0);
        finish_test(5, "dropped regions and coverage", mark);

        $display("%0d checks, %0d errors, %0d of 5 tests passed", checks, errors, passed);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
